/* mac_frame_gen.f */
src/frame_gen_pkg.sv
src/crc_byte_stage.sv
src/fcs_accumulator.sv
src/frame_sequencer.sv
src/mac_frame_generator.sv
tests/tb_mac_frame_generator.sv

/* run.sh */
#!/bin/sh
# build and run the MAC frame generator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f mac_frame_gen.f \
    --top-module tb_mac_frame_generator -o tb_sim

output=$(./obj_dir/tb_sim)
echo "$output"

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* src/crc_byte_stage.sv */
`timescale 1ns/10ps

// one byte of the crc update, msb first
module crc_byte_stage
    import frame_gen_pkg::*;
(
    input  crc_t  i_crc,
    input  byte_t i_byte,
    output crc_t  o_crc
);

    crc_t crc;

    always_comb begin
        crc = i_crc ^ {i_byte, 24'h000000};  // byte lands on the top of the register
        for (int i = 0; i < 8; i++) begin
            if (crc[31]) begin
                crc = {crc[30:0], 1'b0} ^ CRC_POLY;
            end else begin
                crc = {crc[30:0], 1'b0};
            end
        end
    end

    assign o_crc = crc;

endmodule

/* src/fcs_accumulator.sv */
`timescale 1ns/10ps

module fcs_accumulator
    import frame_gen_pkg::*;
(
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_frame_start,
    input  logic i_data_strobe,
    input  logic i_fcs_strobe,
    input  crc_t i_next_crc,    // result of the byte stage chain
    output crc_t o_crc,         // running crc, feeds stage 0
    output crc_t o_fcs,
    output logic o_done
);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc  <= CRC_INIT;
            o_fcs  <= '0;
            o_done <= 1'b0;
        end else begin
            if (i_frame_start) begin
                o_crc <= CRC_INIT;      // reseed during the preamble word
            end else if (i_data_strobe) begin
                o_crc <= i_next_crc;
            end

            // fcs strobe sits on the last data word, so fold it in here
            if (i_fcs_strobe) begin
                o_fcs <= ~i_next_crc;
            end else if (i_frame_start) begin
                o_fcs <= '0;
            end

            o_done <= i_fcs_strobe;
        end
    end

endmodule

/* src/frame_gen_pkg.sv */
package frame_gen_pkg;

    // widths with a meaning in the frame
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;     // ethertype or length
    typedef logic [63:0] frame_word_t;
    typedef logic [31:0] crc_t;
    typedef logic [15:0] pay_len_t;      // payload length in bytes

    // request as captured on start, 129 bits
    typedef struct packed {
        mac_addr_t dest;
        mac_addr_t src;
        eth_type_t eth_type;
        pay_len_t  length;
        logic      fixed;                // payload replaced by pattern byte
    } frame_req_t;

    typedef enum logic [1:0] {
        IDLE,
        SEND_PREAMBLE,
        SEND_DATA,
        SEND_FCS
    } seq_state_t;

    // seven 55 bytes then the start frame delimiter
    localparam frame_word_t PREAMBLE_SFD = 64'h55555555555555D5;

    localparam int HEADER_BYTES      = 14;  // dest + src + ethertype
    localparam int MIN_PAYLOAD_BYTES = 46;
    localparam int WORD_BYTES        = 8;

    // crc-32, msb first, no reflection
    localparam crc_t CRC_POLY = 32'h04C11DB7;
    localparam crc_t CRC_INIT = 32'hFFFFFFFF;

endpackage

/* src/frame_sequencer.sv */
`timescale 1ns/10ps

module frame_sequencer
    import frame_gen_pkg::*;
#(
    parameter int    PAYLOAD_BYTES        = 64,
    parameter byte_t PAYLOAD_CHAR_PATTERN = 8'h55
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_start,
    input  frame_req_t                     i_req,
    input  byte_t [0:PAYLOAD_BYTES-1]      i_payload,     // byte 0 in the top bits
    output logic                           o_valid,
    output frame_word_t                    o_frame_out,
    output logic                           o_data_strobe, // header, payload, padding only
    output logic                           o_frame_start,
    output logic                           o_fcs_strobe
);

    // largest padded payload the input can produce
    localparam int MAX_PAYLOAD = (PAYLOAD_BYTES > MIN_PAYLOAD_BYTES) ?
                                 PAYLOAD_BYTES : MIN_PAYLOAD_BYTES;
    localparam int BUF_BYTES   = ((HEADER_BYTES + MAX_PAYLOAD + WORD_BYTES - 1) / WORD_BYTES)
                                 * WORD_BYTES;

    seq_state_t                state;
    pay_len_t                  word_idx;
    pay_len_t                  last_word;
    pay_len_t                  len_c;
    pay_len_t                  pad_len;
    pay_len_t                  word_count;
    byte_t [0:HEADER_BYTES-1]  hdr;
    byte_t                     bytes_d [BUF_BYTES];
    byte_t                     bytes_q [BUF_BYTES];
    frame_word_t               cur_word;

    assign hdr = {i_req.dest, i_req.src, i_req.eth_type};

    // clamp length, then pad up to the minimum payload
    assign len_c   = (i_req.length > PAYLOAD_BYTES) ? pay_len_t'(PAYLOAD_BYTES) : i_req.length;
    assign pad_len = (len_c < MIN_PAYLOAD_BYTES) ? pay_len_t'(MIN_PAYLOAD_BYTES) : len_c;
    assign word_count = pay_len_t'((HEADER_BYTES + pad_len + WORD_BYTES - 1) / WORD_BYTES);

    // byte image of the whole frame, zeros past the payload
    always_comb begin
        for (int k = 0; k < BUF_BYTES; k++) begin
            bytes_d[k] = '0;
        end
        for (int h = 0; h < HEADER_BYTES; h++) begin
            bytes_d[h] = hdr[h];
        end
        for (int p = 0; p < PAYLOAD_BYTES; p++) begin
            if (p < len_c) begin
                bytes_d[HEADER_BYTES + p] = i_req.fixed ? PAYLOAD_CHAR_PATTERN : i_payload[p];
            end
        end
    end

    // image is only written when a request is taken
    always_ff @(posedge clk) begin
        if (state == IDLE && i_start) begin
            bytes_q <= bytes_d;
        end
    end

    // first byte of the word goes in the top bits
    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            cur_word[(WORD_BYTES-1-b)*8 +: 8] = bytes_q[word_idx*WORD_BYTES + b];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= IDLE;
            word_idx      <= '0;
            last_word     <= '0;
            o_valid       <= 1'b0;
            o_frame_out   <= '0;
            o_data_strobe <= 1'b0;
            o_frame_start <= 1'b0;
            o_fcs_strobe  <= 1'b0;
        end else begin
            // strobes and the word drop unless a state drives them
            o_valid       <= 1'b0;
            o_frame_out   <= '0;
            o_data_strobe <= 1'b0;
            o_frame_start <= 1'b0;
            o_fcs_strobe  <= 1'b0;

            case (state)
                IDLE: begin
                    if (i_start) begin
                        last_word <= pay_len_t'(word_count - 16'd1);
                        state     <= SEND_PREAMBLE;
                    end
                end
                SEND_PREAMBLE: begin
                    o_valid       <= 1'b1;
                    o_frame_out   <= PREAMBLE_SFD;
                    o_frame_start <= 1'b1;     // crc reseed, not part of the fcs
                    word_idx      <= '0;
                    state         <= SEND_DATA;
                end
                SEND_DATA: begin
                    o_valid       <= 1'b1;
                    o_frame_out   <= cur_word;
                    o_data_strobe <= 1'b1;
                    word_idx      <= word_idx + 16'd1;
                    if (word_idx == last_word) begin
                        o_fcs_strobe <= 1'b1;  // rides along with the last word
                        state        <= SEND_FCS;
                    end
                end
                SEND_FCS: begin
                    state <= IDLE;             // done pulses from the accumulator now
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* src/mac_frame_generator.sv */
`timescale 1ns/10ps

module mac_frame_generator
    import frame_gen_pkg::*;
#(
    parameter int    PAYLOAD_BYTES        = 64,     // multiple of 8
    parameter byte_t PAYLOAD_CHAR_PATTERN = 8'h55
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  mac_addr_t                 i_dest_address,
    input  mac_addr_t                 i_src_address,
    input  eth_type_t                 i_eth_type,
    input  pay_len_t                  i_payload_length,
    input  byte_t [0:PAYLOAD_BYTES-1] i_payload,
    input  logic                      i_fixed_payload,
    output logic                      o_valid,
    output frame_word_t               o_frame_out,
    output crc_t                      o_fcs,
    output logic                      o_done
);

    frame_req_t req;
    logic       data_strobe;
    logic       frame_start;
    logic       fcs_strobe;
    crc_t       crc_chain [0:WORD_BYTES];   // stage i reads i, drives i+1

    assign req = '{dest: i_dest_address, src: i_src_address, eth_type: i_eth_type,
                   length: i_payload_length, fixed: i_fixed_payload};

    frame_sequencer #(
        .PAYLOAD_BYTES        (PAYLOAD_BYTES),
        .PAYLOAD_CHAR_PATTERN (PAYLOAD_CHAR_PATTERN)
    ) frame_sequencer_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_start       (i_start),
        .i_req         (req),
        .i_payload     (i_payload),
        .o_valid       (o_valid),
        .o_frame_out   (o_frame_out),
        .o_data_strobe (data_strobe),
        .o_frame_start (frame_start),
        .o_fcs_strobe  (fcs_strobe)
    );

    // byte 0 is the msb of the word and goes first
    genvar g;
    generate
        for (g = 0; g < WORD_BYTES; g++) begin : g_crc_stage
            crc_byte_stage crc_byte_stage_inst (
                .i_crc  (crc_chain[g]),
                .i_byte (o_frame_out[(WORD_BYTES-1-g)*8 +: 8]),
                .o_crc  (crc_chain[g+1])
            );
        end
    endgenerate

    fcs_accumulator fcs_accumulator_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_frame_start (frame_start),
        .i_data_strobe (data_strobe),
        .i_fcs_strobe  (fcs_strobe),
        .i_next_crc    (crc_chain[WORD_BYTES]),
        .o_crc         (crc_chain[0]),
        .o_fcs         (o_fcs),
        .o_done        (o_done)
    );

endmodule

/* tests/frame_golden.txt */
# each frame: fixed length dest src ethertype words fcs (all hex)
# then payload bytes 0..31 on one line and bytes 32..63 on the next
0 002E FFFFFFFF0000 000000000000 0000 8 FFFFFFFF
0000000209823B6E000000000000000000000000000000000000000000000000
0000000000000000000000000000AAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAA
0 0000 FFFFFFFF0000 000000000000 0000 8 FFFFFFFF
AAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAA
AAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAA
0 0005 FFFFFFFF0000 000104C11DB7 0000 8 FFFFFFFF
0000000000333333333333333333333333333333333333333333333333333333
3333333333333333333333333333333333333333333333333333333333333333
0 0032 FFFFFFFF0000 000104C11DB7 0000 8 FB3EE248
0000000000000000000000000000000000000000000000000000000000000000
0000000000000000000000000000000000015A5A5A5A5A5A5A5A5A5A5A5A5A5A
1 001E FFFFFFFF0000 000104C11DB7 0000 8 FFFFFFFF
7777777777777777777777777777777777777777777777777777777777777777
7777777777777777777777777777777777777777777777777777777777777777
0 003A FFFFFFFF0000 000000000000 0000 9 F67DC491
0000000104C11DB7000000000000000000000000000000000000000000000000
0000000000000000000000000000000000000000000000000002C3C3C3C3C3C3
0 0040 FFFFFFFF0000 000000000000 0000 A FFFFFFFF
000104C11DB70000000000000000000000000000000000000000000000000000
0000000000000000000000000000000000000000000000000000000209823B6E
0 0064 FFFFFFFF0000 000000000000 0000 A FFFFFFFF
000104C11DB70000000000000000000000000000000000000000000000000000
0000000000000000000000000000000000000000000000000000000209823B6E

/* tests/tb_mac_frame_generator.sv */
`timescale 1ns/10ps

module tb_mac_frame_generator
    import frame_gen_pkg::*;
();

    localparam int    PAY_BYTES = 64;
    localparam byte_t FILL_CHAR = 8'h00;   // fixed-mode byte for this run
    localparam int    MAX_BYTES = 80;      // 14 + 64, rounded up to whole words
    localparam int    CLK_HALF  = 10;

    logic         clk;
    logic         i_rst_n;
    logic         i_start;
    mac_addr_t    i_dest_address;
    mac_addr_t    i_src_address;
    eth_type_t    i_eth_type;
    pay_len_t     i_payload_length;
    logic [511:0] i_payload;
    logic         i_fixed_payload;
    logic         o_valid;
    frame_word_t  o_frame_out;
    crc_t         o_fcs;
    logic         o_done;

    // one entry per golden frame
    logic         g_fixed [$];
    pay_len_t     g_len [$];
    mac_addr_t    g_dest [$];
    mac_addr_t    g_src [$];
    eth_type_t    g_eth [$];
    logic [511:0] g_pay [$];
    int           g_words [$];
    crc_t         g_fcs [$];

    byte_t exp_bytes [MAX_BYTES];   // expected frame image after the preamble
    int    errors;
    int    checks;
    bit    loaded;

    mac_frame_generator #(
        .PAYLOAD_BYTES        (PAY_BYTES),
        .PAYLOAD_CHAR_PATTERN (FILL_CHAR)
    ) mac_frame_generator_inst (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_start          (i_start),
        .i_dest_address   (i_dest_address),
        .i_src_address    (i_src_address),
        .i_eth_type       (i_eth_type),
        .i_payload_length (i_payload_length),
        .i_payload        (i_payload),
        .i_fixed_payload  (i_fixed_payload),
        .o_valid          (o_valid),
        .o_frame_out      (o_frame_out),
        .o_fcs            (o_fcs),
        .o_done           (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic load_golden();
        int           fd;
        int           n;
        string        line;
        string        rows [$];
        logic         f;
        logic [15:0]  l;
        logic [47:0]  d;
        logic [47:0]  s;
        logic [15:0]  e;
        int           w;
        logic [31:0]  c;
        logic [255:0] hi;
        logic [255:0] lo;
        fd = $fopen("tests/frame_golden.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the golden file tests/frame_golden.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                rows.push_back(line);
            end
        end
        $fclose(fd);
        if (rows.size() % 3 != 0) begin
            $display("ERROR: golden file has a frame with missing payload lines");
            errors++;
        end
        for (int r = 0; r + 2 < rows.size(); r += 3) begin
            n = $sscanf(rows[r], "%h %h %h %h %h %h %h", f, l, d, s, e, w, c);
            if (n != 7) begin
                $display("ERROR: golden frame line is badly formed: %s", rows[r]);
                errors++;
            end
            void'($sscanf(rows[r+1], "%h", hi));
            void'($sscanf(rows[r+2], "%h", lo));
            g_fixed.push_back(f);
            g_len.push_back(l);
            g_dest.push_back(d);
            g_src.push_back(s);
            g_eth.push_back(e);
            g_pay.push_back({hi, lo});
            g_words.push_back(w);
            g_fcs.push_back(c);
        end
        if (g_len.size() == 0) begin
            $display("ERROR: golden file holds no frames");
            errors++;
        end
    endtask

    // frame image from the packing rule, returns the data word count
    function automatic int build_expected(input int idx);
        int plen;
        int padded;
        plen = (int'(g_len[idx]) > PAY_BYTES) ? PAY_BYTES : int'(g_len[idx]);
        for (int k = 0; k < MAX_BYTES; k++) begin
            exp_bytes[k] = 8'h00;
        end
        for (int h = 0; h < 6; h++) begin
            exp_bytes[h]     = g_dest[idx][47-8*h -: 8];
            exp_bytes[6 + h] = g_src[idx][47-8*h -: 8];
        end
        exp_bytes[12] = g_eth[idx][15:8];
        exp_bytes[13] = g_eth[idx][7:0];
        for (int p = 0; p < plen; p++) begin
            exp_bytes[14 + p] = g_fixed[idx] ? FILL_CHAR : g_pay[idx][511-8*p -: 8];
        end
        padded = (plen < 46) ? 46 : plen;
        return (14 + padded + 7) / 8;
    endfunction

    // bit-serial crc-32, msb first, inverted at the end
    function automatic crc_t crc_model(input int nbytes);
        crc_t crc;
        logic fb;
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < nbytes; i++) begin
            for (int b = 7; b >= 0; b--) begin
                fb  = crc[31] ^ exp_bytes[i][b];
                crc = {crc[30:0], 1'b0};
                if (fb) begin
                    crc = crc ^ 32'h04C11DB7;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic frame_word_t word_at(input int w);
        frame_word_t word;
        for (int b = 0; b < 8; b++) begin
            word[63-8*b -: 8] = exp_bytes[8*w + b];
        end
        return word;
    endfunction

    // entered on a falling edge with the DUT idle or on its done cycle
    task automatic run_frame(input int idx, input int gap);
        int   words;
        crc_t model_fcs;
        words     = build_expected(idx);
        model_fcs = crc_model(words * 8);
        check("golden word count", 64'(g_words[idx]), 64'(words));
        check("golden fcs", 64'(g_fcs[idx]), 64'(model_fcs));

        i_dest_address   = g_dest[idx];
        i_src_address    = g_src[idx];
        i_eth_type       = g_eth[idx];
        i_payload_length = g_len[idx];
        i_payload        = g_pay[idx];
        i_fixed_payload  = g_fixed[idx];
        i_start          = 1'b1;
        @(posedge clk);
        @(negedge clk);
        i_start = 1'b0;
        // request captured, preamble follows on the next edge
        check("o_valid", 64'(1'b0), 64'(o_valid));
        check("o_done", 64'(1'b0), 64'(o_done));

        @(negedge clk);
        check("o_valid", 64'(1'b1), 64'(o_valid));
        check("o_frame_out", 64'h55555555555555D5, o_frame_out);
        check("o_done", 64'(1'b0), 64'(o_done));

        for (int w = 0; w < words; w++) begin
            @(negedge clk);
            check("o_valid", 64'(1'b1), 64'(o_valid));
            check("o_frame_out", word_at(w), o_frame_out);
            check("o_done", 64'(1'b0), 64'(o_done));
        end

        @(negedge clk);
        check("o_valid", 64'(1'b0), 64'(o_valid));
        check("o_done", 64'(1'b1), 64'(o_done));
        check("o_fcs", 64'(g_fcs[idx]), 64'(o_fcs));

        repeat (gap) begin
            @(negedge clk);
            check("o_valid", 64'(1'b0), 64'(o_valid));
            check("o_done", 64'(1'b0), 64'(o_done));
            check("o_fcs", 64'(g_fcs[idx]), 64'(o_fcs));   // held until next start
        end
    endtask

    initial begin
        int gap;
        i_rst_n          = 1'b0;
        i_start          = 1'b0;
        i_dest_address   = '0;
        i_src_address    = '0;
        i_eth_type       = '0;
        i_payload_length = '0;
        i_payload        = '0;
        i_fixed_payload  = 1'b0;
        errors           = 0;
        checks           = 0;
        loaded           = 1'b0;
        void'($urandom(35));

        load_golden();
        loaded = 1'b1;

        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        check("o_valid", 64'(1'b0), 64'(o_valid));
        check("o_done", 64'(1'b0), 64'(o_done));
        check("o_frame_out", 64'h0, o_frame_out);
        check("o_fcs", 64'h0, 64'(o_fcs));

        for (int i = 0; i < g_len.size(); i++) begin
            gap = int'($urandom % 32'd4);   // 0 starts on the done cycle
            if (i == 0) begin
                gap = 0;                     // first pair always back to back
            end
            run_frame(i, gap);
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog, sized from the golden frames
    initial begin
        int budget;
        wait (loaded);
        budget = 100;
        foreach (g_words[i]) begin
            budget += g_words[i] + 6;
        end
        repeat (budget) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d clock cycles", budget);
        $display("Simulation failed");
        $finish;
    end

endmodule
